// ==== include/autotest_defines.svh ====
// widths are fixed by the cipher under test and are not meant to be changed
// record offsets assume the 31-byte layout at the start of each SD block
`ifndef AUTOTEST_DEFINES_SVH
`define AUTOTEST_DEFINES_SVH

// data widths
`define AT_BYTE_W        8
`define AT_BLOCK_W       64
`define AT_KEY_W         80
`define AT_ADDR_W        32
`define AT_COUNT_W       32

// record framing
`define AT_SIGNATURE     32'hAABBCCDD
`define AT_START_BLOCK   32'h0010_0000
`define AT_SECTOR_BYTES  512

// byte offsets inside a record
`define AT_OFS_BLOCK     4
`define AT_OFS_KEY       12
`define AT_OFS_MODE      22
`define AT_OFS_EXPECT    23
`define AT_OFS_END       31

`endif

// ==== hw/autotest_pkg.sv ====
// shared types for the self-test sequencer
// state encodings appear on debug view 0, so their order is fixed
package autotest_pkg;

  `include "autotest_defines.svh"

  typedef logic [`AT_BYTE_W-1:0]  byte_t;
  typedef logic [`AT_BLOCK_W-1:0] block_t;
  typedef logic [`AT_KEY_W-1:0]   key_t;
  typedef logic [`AT_ADDR_W-1:0]  sd_addr_t;
  typedef logic [`AT_COUNT_W-1:0] count_t;

  typedef enum logic [4:0] {
    INIT,
    SD_RESET,
    SD_RESET_WAIT,
    IDLE,
    BLOCK_REQ,
    BLOCK_WAIT,
    BYTE_REQ,
    BYTE_WAIT,
    BYTE_TAKE,
    SKIP_REST,
    CHECK_SIG,
    RUN,
    CAPTURE,
    COMPARE,
    NEXT_BLOCK,
    HALT
  } ctrl_state_e;

endpackage

// ==== hw/autotest_ifs.sv ====
// internal buses between the controller and its datapath blocks
// all strobes are single-cycle pulses in the clk domain
`timescale 1ns/100ps

interface vec_if;
  logic clear;
  logic byte_stb;
  logic last_byte;
  logic sig_ok;
  logic decrypt;

  modport control (
    output clear,
    output byte_stb,
    input  last_byte,
    input  sig_ok,
    input  decrypt
  );

  modport loader (
    input  clear,
    input  byte_stb,
    output last_byte,
    output sig_ok,
    output decrypt
  );
endinterface

interface chk_if;
  logic clear;
  logic capture;
  logic compare;
  logic mismatch;

  modport control (output clear, output capture, output compare, input mismatch);
  modport check (input clear, input capture, input compare, output mismatch);
endinterface

// ==== hw/autotest_ctrl.sv ====
// sequencer FSM; expects the SD host to raise busy for every request
// halts for good after a record with a bad signature
`timescale 1ns/100ps
`include "autotest_defines.svh"

module autotest_ctrl (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    spi_busy_i,
  output logic                    spi_rst_o,
  output logic                    spi_r_block_o,
  output logic                    spi_r_byte_o,
  output autotest_pkg::sd_addr_t  spi_block_addr_o,
  input  logic                    uut_end_enc_i,
  input  logic                    uut_end_dec_i,
  output logic                    uut_rst_o,
  vec_if.control                  vec,
  chk_if.control                  chk,
  output autotest_pkg::ctrl_state_e state_o
);

  autotest_pkg::ctrl_state_e state_q;
  autotest_pkg::ctrl_state_e state_d;
  autotest_pkg::sd_addr_t    addr_q;
  logic                      addr_inc;
  logic                      first_q;
  logic                      end_hit;

  // only the flag matching the loaded mode ends a test
  assign end_hit = vec.decrypt ? uut_end_dec_i : uut_end_enc_i;

  assign uut_rst_o        = (state_q != autotest_pkg::RUN);
  assign spi_block_addr_o = addr_q;
  assign state_o          = state_q;

  // loader restarts its byte count on the first byte of each record
  assign vec.clear = (state_q == autotest_pkg::BYTE_TAKE) && first_q;

  always_comb begin
    state_d       = state_q;
    spi_rst_o     = 1'b0;
    spi_r_block_o = 1'b0;
    spi_r_byte_o  = 1'b0;
    vec.byte_stb  = 1'b0;
    chk.clear     = 1'b0;
    chk.capture   = 1'b0;
    chk.compare   = 1'b0;
    addr_inc      = 1'b0;
    case (state_q)
      autotest_pkg::INIT: begin
        state_d = autotest_pkg::SD_RESET;
      end
      autotest_pkg::SD_RESET: begin
        spi_rst_o = 1'b1;
        if (spi_busy_i) state_d = autotest_pkg::SD_RESET_WAIT;
      end
      autotest_pkg::SD_RESET_WAIT: begin
        if (!spi_busy_i) state_d = autotest_pkg::IDLE;
      end
      autotest_pkg::IDLE: begin
        chk.clear = 1'b1;
        state_d   = autotest_pkg::BLOCK_REQ;
      end
      autotest_pkg::BLOCK_REQ: begin
        spi_r_block_o = 1'b1;
        if (spi_busy_i) state_d = autotest_pkg::BLOCK_WAIT;
      end
      autotest_pkg::BLOCK_WAIT: begin
        spi_r_block_o = 1'b1;
        if (!spi_busy_i) state_d = autotest_pkg::BYTE_REQ;
      end
      autotest_pkg::BYTE_REQ: begin
        spi_r_block_o = 1'b1;
        spi_r_byte_o  = 1'b1;
        if (spi_busy_i) state_d = autotest_pkg::BYTE_WAIT;
      end
      autotest_pkg::BYTE_WAIT: begin
        spi_r_block_o = 1'b1;
        if (!spi_busy_i) state_d = autotest_pkg::BYTE_TAKE;
      end
      autotest_pkg::BYTE_TAKE: begin
        // data stays valid until the next request
        spi_r_block_o = 1'b1;
        vec.byte_stb  = 1'b1;
        if (vec.last_byte) begin
          state_d = autotest_pkg::SKIP_REST;
        end else begin
          state_d = autotest_pkg::BYTE_REQ;
        end
      end
      autotest_pkg::SKIP_REST: begin
        // block read released here
        state_d = autotest_pkg::CHECK_SIG;
      end
      autotest_pkg::CHECK_SIG: begin
        state_d = vec.sig_ok ? autotest_pkg::RUN : autotest_pkg::HALT;
      end
      autotest_pkg::RUN: begin
        if (end_hit) state_d = autotest_pkg::CAPTURE;
      end
      autotest_pkg::CAPTURE: begin
        chk.capture = 1'b1;
        state_d     = autotest_pkg::COMPARE;
      end
      autotest_pkg::COMPARE: begin
        chk.compare = 1'b1;
        state_d     = autotest_pkg::NEXT_BLOCK;
      end
      autotest_pkg::NEXT_BLOCK: begin
        addr_inc = 1'b1;
        state_d  = autotest_pkg::IDLE;
      end
      autotest_pkg::HALT: begin
        state_d = autotest_pkg::HALT;
      end
      default: state_d = autotest_pkg::INIT;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= autotest_pkg::INIT;
      addr_q  <= `AT_START_BLOCK;
      first_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (addr_inc) addr_q <= addr_q + 1'b1;
      if (state_q == autotest_pkg::BLOCK_REQ) begin
        first_q <= 1'b1;
      end else if (state_q == autotest_pkg::BYTE_TAKE) begin
        first_q <= 1'b0;
      end
    end
  end

  a_byte_in_block: assert property (@(posedge clk) disable iff (rst)
    spi_r_byte_o |-> spi_r_block_o)
    else $error("byte request outside a block read");

  // the UUT only runs on a record whose signature matched
  a_uut_run_only: assert property (@(posedge clk) disable iff (rst)
    !uut_rst_o |-> vec.sig_ok)
    else $error("UUT out of reset without a valid record signature");

endmodule

// ==== hw/vector_loader.sv ====
// steers record bytes into the UUT operand registers by offset
// bytes past the expected-result field are counted and dropped
`timescale 1ns/100ps
`include "autotest_defines.svh"

module vector_loader (
  input  logic                 clk,
  input  logic                 rst,
  input  autotest_pkg::byte_t  spi_data_i,
  vec_if.loader                vec,
  output autotest_pkg::block_t block_o,
  output autotest_pkg::key_t   key_o,
  output autotest_pkg::block_t expected_o
);

  logic [9:0]           byte_cnt;
  logic [9:0]           idx;
  logic [31:0]          sig_q;
  autotest_pkg::block_t block_q;
  autotest_pkg::key_t   key_q;
  autotest_pkg::block_t expected_q;
  logic                 mode_q;

  // a clear arriving with a strobe means byte 0
  assign idx = vec.clear ? '0 : byte_cnt;

  assign vec.last_byte = (idx == `AT_SECTOR_BYTES - 1);
  assign vec.sig_ok    = (sig_q == `AT_SIGNATURE);
  assign vec.decrypt   = mode_q;

  assign block_o    = block_q;
  assign key_o      = key_q;
  assign expected_o = expected_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      byte_cnt <= '0;
    end else if (vec.byte_stb) begin
      byte_cnt <= idx + 10'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (vec.clear) begin
      sig_q      <= '0;
      block_q    <= '0;
      key_q      <= '0;
      expected_q <= '0;
      mode_q     <= 1'b0;
    end
    if (vec.byte_stb) begin
      // signature is big-endian and every other field little-endian
      if (idx < `AT_OFS_BLOCK) begin
        sig_q[(`AT_OFS_BLOCK - 1 - idx) * 8 +: 8] <= spi_data_i;
      end else if (idx < `AT_OFS_KEY) begin
        block_q[(idx - `AT_OFS_BLOCK) * 8 +: 8] <= spi_data_i;
      end else if (idx < `AT_OFS_MODE) begin
        key_q[(idx - `AT_OFS_KEY) * 8 +: 8] <= spi_data_i;
      end else if (idx == `AT_OFS_MODE) begin
        mode_q <= spi_data_i[0];
      end else if (idx < `AT_OFS_END) begin
        expected_q[(idx - `AT_OFS_EXPECT) * 8 +: 8] <= spi_data_i;
      end
    end
  end

  a_no_overrun: assert property (@(posedge clk) disable iff (rst)
    vec.byte_stb |-> idx < `AT_SECTOR_BYTES)
    else $error("byte strobe beyond end of record");

endmodule

// ==== hw/result_checker.sv ====
// compares the captured UUT result with the expected block
// error count is cleared only by reset
`timescale 1ns/100ps

module result_checker (
  input  logic                 clk,
  input  logic                 rst,
  input  autotest_pkg::block_t uut_result_i,
  input  autotest_pkg::block_t expected_i,
  chk_if.check                 chk,
  output autotest_pkg::count_t err_count_o
);

  autotest_pkg::block_t result_q;
  autotest_pkg::count_t err_q;

  always_ff @(posedge clk) begin
    if (chk.clear) begin
      result_q <= '0;
    end else if (chk.capture) begin
      result_q <= uut_result_i;
    end
  end

  // valid in the compare cycle after result_q has settled
  assign chk.mismatch = (result_q != expected_i);

  always_ff @(posedge clk) begin
    if (rst) begin
      err_q <= '0;
    end else if (chk.compare && chk.mismatch) begin
      err_q <= err_q + 1'b1;
    end
  end

  assign err_count_o = err_q;

  a_cap_cmp_apart: assert property (@(posedge clk) disable iff (rst)
    !(chk.capture && chk.compare))
    else $error("capture and compare in the same cycle");

endmodule

// ==== hw/test_monitor.sv ====
// execution and completed-test statistics plus the debug view select
// view 0 packs address[15:0] above the state code
`timescale 1ns/100ps

module test_monitor (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      byte_first_i,
  input  logic                      uut_rst_i,
  input  logic                      compare_i,
  input  autotest_pkg::ctrl_state_e state_i,
  input  autotest_pkg::sd_addr_t    block_addr_i,
  input  autotest_pkg::count_t      err_count_i,
  input  logic [1:0]                debug_sel_i,
  output autotest_pkg::count_t      debug_o
);

  autotest_pkg::count_t exec_q;
  autotest_pkg::count_t done_q;

  // cycles spent out of reset in the current test
  always_ff @(posedge clk) begin
    if (rst) begin
      exec_q <= '0;
    end else if (byte_first_i) begin
      exec_q <= '0;
    end else if (!uut_rst_i) begin
      exec_q <= exec_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      done_q <= '0;
    end else if (compare_i) begin
      done_q <= done_q + 1'b1;
    end
  end

  always_comb begin
    case (debug_sel_i)
      2'd0:    debug_o = {block_addr_i[15:0], 11'd0, state_i};
      2'd1:    debug_o = err_count_i;
      2'd2:    debug_o = exec_q;
      default: debug_o = done_q;
    endcase
  end

endmodule

// ==== hw/autotest_top.sv ====
// self-test sequencer top; SD host and cipher UUT sit outside
// spi_err_i is not monitored and host errors surface as signature failures
`timescale 1ns/100ps

module autotest_top (
  input  logic                 clk,
  input  logic                 rst,
  // SD host
  input  logic                 spi_busy_i,
  input  autotest_pkg::byte_t  spi_data_i,
  input  logic                 spi_err_i,
  output logic                 spi_rst_o,
  output logic                 spi_r_block_o,
  output logic                 spi_r_byte_o,
  output autotest_pkg::sd_addr_t spi_block_addr_o,
  // cipher UUT
  output logic                 uut_rst_o,
  output autotest_pkg::block_t uut_block_o,
  output autotest_pkg::key_t   uut_key_o,
  output logic                 uut_decrypt_o,
  input  autotest_pkg::block_t uut_result_i,
  input  logic                 uut_end_enc_i,
  input  logic                 uut_end_dec_i,
  // debug
  input  logic [1:0]           debug_sel_i,
  output autotest_pkg::count_t debug_o
);

  vec_if vec_bus ();
  chk_if chk_bus ();

  autotest_pkg::ctrl_state_e state;
  autotest_pkg::block_t      expected;
  autotest_pkg::count_t      err_count;

  assign uut_decrypt_o = vec_bus.decrypt;

  autotest_ctrl u_ctrl (
    .clk              (clk),
    .rst              (rst),
    .spi_busy_i       (spi_busy_i),
    .spi_rst_o        (spi_rst_o),
    .spi_r_block_o    (spi_r_block_o),
    .spi_r_byte_o     (spi_r_byte_o),
    .spi_block_addr_o (spi_block_addr_o),
    .uut_end_enc_i    (uut_end_enc_i),
    .uut_end_dec_i    (uut_end_dec_i),
    .uut_rst_o        (uut_rst_o),
    .vec              (vec_bus),
    .chk              (chk_bus),
    .state_o          (state)
  );

  vector_loader u_loader (
    .clk        (clk),
    .rst        (rst),
    .spi_data_i (spi_data_i),
    .vec        (vec_bus),
    .block_o    (uut_block_o),
    .key_o      (uut_key_o),
    .expected_o (expected)
  );

  result_checker u_checker (
    .clk          (clk),
    .rst          (rst),
    .uut_result_i (uut_result_i),
    .expected_i   (expected),
    .chk          (chk_bus),
    .err_count_o  (err_count)
  );

  // clear coincides with the first byte strobe of a record
  test_monitor u_monitor (
    .clk          (clk),
    .rst          (rst),
    .byte_first_i (vec_bus.clear),
    .uut_rst_i    (uut_rst_o),
    .compare_i    (chk_bus.compare),
    .state_i      (state),
    .block_addr_i (spi_block_addr_o),
    .err_count_i  (err_count),
    .debug_sel_i  (debug_sel_i),
    .debug_o      (debug_o)
  );

endmodule

// ==== verification/tb_models.sv ====
// behavioural SD host and cipher UUT for the sequencer testbench
// both draw their delays from $random with seed 85
`timescale 1ns/100ps

module sd_card_model (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   spi_rst_i,
  input  logic                   spi_r_block_i,
  input  logic                   spi_r_byte_i,
  input  autotest_pkg::sd_addr_t block_addr_i,
  input  autotest_pkg::byte_t    rd_data_i,
  output autotest_pkg::sd_addr_t rd_block_o,
  output logic [8:0]             rd_index_o,
  output logic                   busy_o,
  output autotest_pkg::byte_t    data_o
);

  integer     seed;
  logic [2:0] wait_q;
  logic       open_q;
  logic       byte_q;
  logic [8:0] next_idx;

  initial seed = 85;

  always @(posedge clk) begin
    if (rst) begin
      busy_o     <= 1'b0;
      wait_q     <= 3'd0;
      open_q     <= 1'b0;
      byte_q     <= 1'b0;
      next_idx   <= 9'd0;
      data_o     <= 8'd0;
      rd_block_o <= 32'd0;
      rd_index_o <= 9'd0;
    end else if (busy_o) begin
      // byte appears together with the fall of busy
      if (wait_q == 3'd1) begin
        busy_o <= 1'b0;
        if (byte_q) data_o <= rd_data_i;
      end
      wait_q <= wait_q - 3'd1;
    end else begin
      if (!spi_r_block_i) open_q <= 1'b0;
      byte_q <= spi_r_byte_i;
      if (spi_rst_i || spi_r_byte_i || (spi_r_block_i && !open_q)) begin
        busy_o <= 1'b1;
        wait_q <= 3'd1 + 3'($unsigned($random(seed)) % 32'd4);
      end
      if (spi_r_block_i && !open_q) begin
        open_q     <= 1'b1;
        rd_block_o <= block_addr_i;
        next_idx   <= 9'd0;
      end else if (spi_r_byte_i) begin
        rd_index_o <= next_idx;
        next_idx   <= next_idx + 9'd1;
      end
    end
  end

endmodule

module cipher_uut_model (
  input  logic                 clk,
  input  logic                 rst_i,
  input  autotest_pkg::block_t block_i,
  input  autotest_pkg::key_t   key_i,
  input  logic                 decrypt_i,
  output autotest_pkg::block_t result_o,
  output logic                 end_enc_o,
  output logic                 end_dec_o
);

  integer     seed;
  logic [4:0] delay_q;

  initial seed = 85;

  // result is left untouched in reset so it can still be captured
  always @(posedge clk) begin
    if (rst_i) begin
      end_enc_o <= 1'b0;
      end_dec_o <= 1'b0;
      delay_q   <= 5'd3 + 5'($unsigned($random(seed)) % 32'd18);
    end else if (delay_q > 5'd1) begin
      delay_q <= delay_q - 5'd1;
    end else if (!end_enc_o && !end_dec_o) begin
      result_o  <= decrypt_i ? ~(block_i ^ key_i[63:0]) : (block_i ^ key_i[63:0]);
      end_enc_o <= !decrypt_i;
      end_dec_o <= decrypt_i;
    end
  end

endmodule

// ==== verification/tb_autotest.sv ====
// six-record self-test run with two wrong expected blocks and a badly signed last record
// stops at the first failed check
`timescale 1ns/100ps
`include "autotest_defines.svh"

module tb_autotest;

  localparam int CLK_NS = 4;
  localparam longint WATCHDOG_NS = 6 * `AT_SECTOR_BYTES * 12 * CLK_NS;

  logic clk;
  logic rst;
  logic spi_busy_i, spi_err_i, spi_rst_o, spi_r_block_o, spi_r_byte_o;
  autotest_pkg::byte_t    spi_data_i;
  autotest_pkg::sd_addr_t spi_block_addr_o;
  logic uut_rst_o, uut_decrypt_o, uut_end_enc_i, uut_end_dec_i;
  autotest_pkg::block_t uut_block_o, uut_result_i;
  autotest_pkg::key_t   uut_key_o;
  logic [1:0]           debug_sel_i;
  autotest_pkg::count_t debug_o;

  integer seed;
  autotest_pkg::block_t rec_block [0:7];
  autotest_pkg::key_t   rec_key [0:7];
  autotest_pkg::block_t rec_expect [0:7];
  logic                 rec_mode [0:7];
  logic                 rec_bad [0:7];
  autotest_pkg::byte_t  rec_mem [0:255];

  autotest_pkg::sd_addr_t sd_rd_block;
  logic [8:0]             sd_rd_index;
  autotest_pkg::byte_t    sd_rd_data;
  logic [2:0]             cur_rec;
  autotest_pkg::block_t   exp_block;
  autotest_pkg::key_t     exp_key;
  logic                   exp_mode;
  autotest_pkg::count_t   low_cycles, exec_base, errs_expected;
  autotest_pkg::sd_addr_t prev_addr;
  logic                   halted;
  logic                   block_seen;

  autotest_top u_autotest_top (.*);

  sd_card_model u_sd_card (
    .clk (clk), .rst (rst), .spi_rst_i (spi_rst_o), .spi_r_block_i (spi_r_block_o),
    .spi_r_byte_i (spi_r_byte_o), .block_addr_i (spi_block_addr_o), .rd_data_i (sd_rd_data),
    .rd_block_o (sd_rd_block), .rd_index_o (sd_rd_index), .busy_o (spi_busy_i),
    .data_o (spi_data_i)
  );

  cipher_uut_model u_cipher (
    .clk (clk), .rst_i (uut_rst_o), .block_i (uut_block_o), .key_i (uut_key_o),
    .decrypt_i (uut_decrypt_o), .result_o (uut_result_i), .end_enc_o (uut_end_enc_i),
    .end_dec_o (uut_end_dec_i)
  );

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "run stopped");
  endtask

  // fields as laid out in the record; unused tail gets an address pattern
  function automatic autotest_pkg::byte_t record_byte(input autotest_pkg::sd_addr_t blk,
                                                       input logic [8:0] idx);
    logic [11:0] flat;
    flat = {3'(blk - `AT_START_BLOCK), idx};
    if (idx < `AT_OFS_END) return rec_mem[{flat[11:9], idx[4:0]}];
    return flat[7:0] ^ flat[11:4];
  endfunction

  task automatic build_records();
    autotest_pkg::block_t good;
    logic [31:0] sig;
    logic [7:0]  mode_byte;
    int          r, k;
    for (r = 0; r < 6; r++) begin
      rec_block[r] = {$random(seed), $random(seed)};
      rec_key[r]   = {16'($random(seed)), $random(seed), $random(seed)};
      mode_byte    = 8'($random(seed));
      rec_mode[r]  = mode_byte[0];
      good = rec_block[r] ^ rec_key[r][63:0];
      if (rec_mode[r]) good = ~good;
      rec_bad[r]    = (r == 1) || (r == 3);
      rec_expect[r] = rec_bad[r] ? good ^ {32'($random(seed)), 32'h1} : good;
      sig = (r == 5) ? ~`AT_SIGNATURE : `AT_SIGNATURE;
      for (k = 0; k < 4; k++) rec_mem[r*32 + k] = sig[(3-k)*8 +: 8];
      for (k = 0; k < 8; k++) begin
        rec_mem[r*32 + `AT_OFS_BLOCK + k]  = rec_block[r][k*8 +: 8];
        rec_mem[r*32 + `AT_OFS_EXPECT + k] = rec_expect[r][k*8 +: 8];
      end
      for (k = 0; k < 10; k++) rec_mem[r*32 + `AT_OFS_KEY + k] = rec_key[r][k*8 +: 8];
      rec_mem[r*32 + `AT_OFS_MODE] = mode_byte;
    end
  endtask

  task automatic wait_block_advance(input autotest_pkg::sd_addr_t from);
    @(negedge clk);
    while (spi_block_addr_o == from) @(negedge clk);
  endtask

  // views 1 and 2 between the end of one record and the load of the next
  task automatic check_statistics(input int r);
    autotest_pkg::count_t exec_expected;
    if (rec_bad[r]) errs_expected = errs_expected + 32'd1;
    @(posedge clk) debug_sel_i <= 2'd1;
    @(negedge clk);
    assert (debug_o == errs_expected) else
      report_failure($sformatf("error: debug_o view 1 = %h, expected %h",
                               debug_o, errs_expected));
    exec_expected = low_cycles - exec_base;
    exec_base     = low_cycles;
    @(posedge clk) debug_sel_i <= 2'd2;
    @(negedge clk);
    assert (debug_o == exec_expected) else
      report_failure($sformatf("error: debug_o view 2 = %h, expected %h",
                               debug_o, exec_expected));
  endtask

  always_comb sd_rd_data = record_byte(sd_rd_block, sd_rd_index);

  always_comb begin
    cur_rec   = 3'(spi_block_addr_o - `AT_START_BLOCK);
    exp_block = rec_block[cur_rec];
    exp_key   = rec_key[cur_rec];
    exp_mode  = rec_mode[cur_rec];
  end

  always @(negedge clk) begin
    if (!rst && !uut_rst_o) low_cycles <= low_cycles + 32'd1;
  end

  // SD host reset belongs before the first block read only
  always @(posedge clk) begin
    if (rst) begin
      block_seen <= 1'b0;
    end else if (spi_r_block_o) begin
      block_seen <= 1'b1;
    end
  end

  a_block: assert property (@(posedge clk) disable iff (rst)
    !uut_rst_o |-> uut_block_o == exp_block)
    else report_failure($sformatf("error: uut_block_o = %h, expected %h",
                                  uut_block_o, exp_block));
  a_key: assert property (@(posedge clk) disable iff (rst)
    !uut_rst_o |-> uut_key_o == exp_key)
    else report_failure($sformatf("error: uut_key_o = %h, expected %h", uut_key_o, exp_key));
  a_mode: assert property (@(posedge clk) disable iff (rst)
    !uut_rst_o |-> uut_decrypt_o == exp_mode)
    else report_failure($sformatf("error: uut_decrypt_o = %h, expected %h",
                                  uut_decrypt_o, exp_mode));
  a_byte_req: assert property (@(posedge clk) disable iff (rst) spi_r_byte_o |-> spi_r_block_o)
    else report_failure("byte read requested outside a block read");
  a_sd_rst_once: assert property (@(posedge clk) disable iff (rst)
    block_seen |-> !spi_rst_o)
    else report_failure("SD host reset requested again after the first block read");
  a_halt_idle: assert property (@(posedge clk) disable iff (rst) halted |-> !spi_r_block_o)
    else report_failure("block read requested after the bad signature");
  a_halt_addr: assert property (@(posedge clk) disable iff (rst)
    halted |-> spi_block_addr_o == `AT_START_BLOCK + 32'd5)
    else report_failure($sformatf("error: spi_block_addr_o = %h after halt, expected %h",
                                  spi_block_addr_o, `AT_START_BLOCK + 32'd5));

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    report_failure("timeout: the sequencer did not get through the six records in time");
  end

  initial begin
    seed          = 85;
    rst           = 1'b1;
    spi_err_i     = 1'b0;
    debug_sel_i   = 2'd1;
    low_cycles    = '0;
    exec_base     = '0;
    errs_expected = '0;
    halted        = 1'b0;
    build_records();
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    assert (spi_block_addr_o == `AT_START_BLOCK) else
      report_failure($sformatf("error: spi_block_addr_o = %h, expected %h",
                               spi_block_addr_o, `AT_START_BLOCK));
    prev_addr = spi_block_addr_o;
    for (int r = 0; r < 5; r++) begin
      wait_block_advance(prev_addr);
      assert (spi_block_addr_o == `AT_START_BLOCK + 32'(r + 1)) else
        report_failure($sformatf("error: spi_block_addr_o = %h, expected %h",
                                 spi_block_addr_o, `AT_START_BLOCK + 32'(r + 1)));
      prev_addr = spi_block_addr_o;
      check_statistics(r);
    end
    // HALT is state code 15 and ends the sixth record
    @(posedge clk) debug_sel_i <= 2'd0;
    @(negedge clk);
    while (debug_o[4:0] != 5'd15) @(negedge clk);
    halted = 1'b1;
    assert (debug_o == {16'h0005, 11'd0, 5'd15}) else
      report_failure($sformatf("error: debug_o view 0 = %h, expected %h",
                               debug_o, {16'h0005, 11'd0, 5'd15}));
    @(posedge clk) debug_sel_i <= 2'd3;
    @(negedge clk);
    assert (debug_o == 32'd5) else
      report_failure($sformatf("error: debug_o view 3 = %h, expected %h", debug_o, 32'd5));
    repeat (200) @(posedge clk);
    $display("TEST PASSED");
    $finish;
  end

endmodule

// ==== autotest.f ====
+incdir+include
hw/autotest_pkg.sv
hw/autotest_ifs.sv
hw/autotest_ctrl.sv
hw/vector_loader.sv
hw/result_checker.sv
hw/test_monitor.sv
hw/autotest_top.sv
verification/tb_models.sv
verification/tb_autotest.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_autotest
FILELIST = autotest.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	-./obj_dir/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
